/* bench/rx_checker.sv */
`include "rx_config.svh"

module rx_checker import rx_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_ni,
    input  iq_stream_t  sample_i,
    input  logic [15:0] cfo_inc_i,
    input  iq_stream_t  decim_i,
    input  pss_report_t report_i,
    input  sym_out_t    sym_i,
    input  logic        row_end_i,
    input  logic [1:0]  exp_nid2_i,   // 3 means no report expected
    input  logic        done_i,
    output int          errors_o
);

    logic [15:0] phase;
    iq_t         m1;                  // previous mixed sample
    iq_t         m2;                  // the one before
    logic        odd;
    iq_t         decim_q[$];
    sym_out_t    sym_q[$];
    iq_t         win [`RX_PSS_LEN];   // model of the correlator window, [0] oldest
    int          errors;
    int          reports;
    logic [1:0]  got_nid2;
    int          state;               // 0 search, 1 offset wait, 2 gate
    int          cnt;
    logic [1:0]  nid2;

    assign errors_o = errors;

    function automatic iq_t mix(input iq_t x, input logic [2:0] idx);
        int  c;
        int  s;
        iq_t y;
        c    = nco_cos(idx);
        s    = nco_sin(idx);
        y.re = (x.re * c + x.im * s) >>> 7; // keeps the low sample bits
        y.im = (x.im * c - x.re * s) >>> 7;
        return y;
    endfunction

    // 1 + 2 z^-1 + z^-2, gain of 4 removed
    function automatic iq_t decimate(input iq_t a, input iq_t b, input iq_t c);
        iq_t y;
        y.re = (int'(a.re) + 2 * b.re + c.re) >>> 2;
        y.im = (int'(a.im) + 2 * b.im + c.im) >>> 2;
        return y;
    endfunction

    // largest |re| + |im| of the three sign-only sums over the model window
    function automatic int peak_metric();
        int sr;
        int si;
        int m;
        int best;
        best = 0;
        for (int k = 0; k < 3; k++) begin
            sr = 0;
            si = 0;
            for (int i = 0; i < `RX_PSS_LEN; i++) begin
                if (pss_tap(k, i)) begin
                    sr -= win[i].re;
                    si -= win[i].im;
                end else begin
                    sr += win[i].re;
                    si += win[i].im;
                end
            end
            m = (sr < 0 ? -sr : sr) + (si < 0 ? -si : si);
            if (m > best) best = m;
        end
        return best;
    endfunction

    // everything is sampled mid-cycle, away from the driving edge
    always @(negedge clk_i) begin
        iq_t      mx;
        iq_t      e;
        sym_out_t s;
        sym_out_t g;
        int       pm;
        if (!reset_ni) begin
            phase   = '0;
            m1      = '0;
            m2      = '0;
            odd     = 1'b0;
            state   = 0;
            cnt     = 0;
            reports = 0;
            for (int i = 0; i < `RX_PSS_LEN; i++) begin
                win[i] = '0;
            end
            decim_q.delete();
            sym_q.delete();
        end else begin
            if (sample_i.valid) begin
                mx    = mix(sample_i.data, phase[15:13]);
                phase = phase + cfo_inc_i;
                if (odd) decim_q.push_back(decimate(mx, m1, m2));
                m2  = m1;
                m1  = mx;
                odd = !odd;
            end
            if (sym_i.valid) begin
                if (sym_q.size() == 0) begin
                    $display("sym_o valid while no symbol sample was due");
                    errors++;
                end else begin
                    g = sym_q.pop_front();
                    if (sym_i.sym_start !== g.sym_start) begin
                        $display("error sym_o.sym_start exp %h got %h", g.sym_start,
                                 sym_i.sym_start);
                        errors++;
                    end
                    if (sym_i.nid2 !== g.nid2) begin
                        $display("error sym_o.nid2 exp %h got %h", g.nid2, sym_i.nid2);
                        errors++;
                    end
                    if (sym_i.hard_bit !== g.hard_bit) begin
                        $display("error sym_o.hard_bit exp %h got %h", g.hard_bit,
                                 sym_i.hard_bit);
                        errors++;
                    end
                end
            end
            // the report comes from the window before this cycle's sample
            if (report_i.valid) begin
                pm = peak_metric();
                if (report_i.metric !== pm) begin
                    $display("error report_o.metric exp %h got %h", pm, report_i.metric);
                    errors++;
                end
            end
            if (decim_i.valid) begin
                if (decim_q.size() == 0) begin
                    $display("decim_o valid with no input pair behind it");
                    errors++;
                    e = decim_i.data;
                end else begin
                    e = decim_q.pop_front();
                    if (decim_i.data.re !== e.re) begin
                        $display("error decim_o.re exp %h got %h", e.re, decim_i.data.re);
                        errors++;
                    end
                    if (decim_i.data.im !== e.im) begin
                        $display("error decim_o.im exp %h got %h", e.im, decim_i.data.im);
                        errors++;
                    end
                end
                for (int i = 0; i < `RX_PSS_LEN - 1; i++) begin
                    win[i] = win[i+1];
                end
                win[`RX_PSS_LEN-1] = e;
                if (state == 1) begin
                    cnt++;
                    if (cnt == `RX_SYM_OFFSET) begin
                        state = 2;
                        cnt   = 0;
                    end
                end else if (state == 2) begin
                    s.valid     = 1'b1;
                    s.sym_start = (cnt == 0);
                    s.nid2      = nid2;
                    s.hard_bit  = ~e.re[`RX_SAMPLE_DW-1];
                    sym_q.push_back(s);
                    cnt++;
                    if (cnt == `RX_SYM_LEN) state = 0;
                end
            end
            if (report_i.valid) begin
                reports++;
                got_nid2 = report_i.nid2;
                if (state == 0) begin
                    state = 1;
                    cnt   = 0;
                    nid2  = report_i.nid2;
                end
            end
            if (row_end_i) begin
                if (exp_nid2_i == 2'd3 && reports != 0) begin
                    $display("PSS report seen where none should appear");
                    errors++;
                end else if (exp_nid2_i != 2'd3 && reports != 1) begin
                    $display("expected one PSS report, saw %0d", reports);
                    errors++;
                end else if (exp_nid2_i != 2'd3 && got_nid2 !== exp_nid2_i) begin
                    $display("error report_o.nid2 exp %h got %h", exp_nid2_i, got_nid2);
                    errors++;
                end
                reports = 0;
            end
            if (done_i) begin
                if (decim_q.size() != 0) begin
                    $display("%0d decimated outputs never came out", decim_q.size());
                    errors++;
                end
                if (sym_q.size() != 0) begin
                    $display("%0d symbol samples never came out", sym_q.size());
                    errors++;
                end
            end
        end
    end

endmodule

/* bench/tb_receiver.sv */
`include "rx_config.svh"

module tb_receiver import rx_pkg::*;;

    localparam int N_ROWS = 8;
    localparam int GAP    = 8;              // idle cycles that flush the pipeline
    localparam int AMP    = 480;

    // cfo, pss index (3 none), amplitude, noise samples, payload bits, expected nid2
    logic [15:0] cfo_tab   [N_ROWS] = '{16'h0, 16'h0, 16'h0, 16'h0800, 16'h2000,
                                        16'h0, 16'h0, 16'h0};
    int          pss_tab   [N_ROWS] = '{0, 1, 2, 3, 3, 1, 2, 0};
    int          amp_tab   [N_ROWS] = '{AMP, AMP, AMP, 16, 16, AMP, AMP, AMP};
    int          noise_tab [N_ROWS] = '{20, 20, 20, 32, 16, 20, 0, 40};
    int          pay_tab   [N_ROWS] = '{48, 48, 48, 0, 0, 0, 24, 48};
    logic [1:0]  exp_tab   [N_ROWS] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd3, 2'd1, 2'd3, 2'd0};

    logic        clk_i;
    logic        reset_ni;
    iq_stream_t  sample_i;
    logic [15:0] cfo_inc_i;
    iq_stream_t  decim_o;
    pss_report_t report_o;
    sym_out_t    sym_o;
    logic        row_end;
    logic [1:0]  exp_nid2;
    logic        done;
    int          errors;
    int          cycles;
    int          limit;
    logic [31:0] lfsr;

    ssb_receiver UUT (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .sample_i  (sample_i),
        .cfo_inc_i (cfo_inc_i),
        .decim_o   (decim_o),
        .report_o  (report_o),
        .sym_o     (sym_o)
    );

    rx_checker checker_i (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .sample_i   (sample_i),
        .cfo_inc_i  (cfo_inc_i),
        .decim_i    (decim_o),
        .report_i   (report_o),
        .sym_i      (sym_o),
        .row_end_i  (row_end),
        .exp_nid2_i (exp_nid2),
        .done_i     (done),
        .errors_o   (errors)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // x^32 + x^22 + x^2 + x + 1, right-shifting form
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic send(input int re, input int im);
        @(posedge clk_i);
        sample_i.valid   <= 1'b1;
        sample_i.data.re <= re;
        sample_i.data.im <= im;
    endtask

    task automatic run_row(input int r);
        logic [31:0]       b;
        logic signed [4:0] nre;
        logic signed [4:0] nim;
        int                v;
        @(posedge clk_i);
        cfo_inc_i <= cfo_tab[r];
        for (int i = 0; i < noise_tab[r]; i++) begin
            take_bits(5, b);
            nre = b[4:0];
            take_bits(5, b);
            nim = b[4:0];
            send(nre, nim);
        end
        if (pss_tab[r] != 3) begin
            for (int p = 0; p < `RX_PSS_LEN; p++) begin
                v = pss_tap(pss_tab[r], p) ? -amp_tab[r] : amp_tab[r];
                send(v, 0);
                send(v, 0);                 // pairs survive decimation by two
            end
        end
        for (int i = 0; i < pay_tab[r]; i++) begin
            take_bits(1, b);
            send(b[0] ? amp_tab[r] / 4 : -amp_tab[r] / 4, 0);
        end
        @(posedge clk_i);
        sample_i.valid <= 1'b0;
        repeat (GAP) @(posedge clk_i);
        exp_nid2 <= exp_tab[r];
        row_end  <= 1'b1;
        @(posedge clk_i);
        row_end  <= 1'b0;
    endtask

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        lfsr      = 32'h9bf9e615;
        cycles    = 0;
        limit     = 200;
        for (int r = 0; r < N_ROWS; r++) begin
            limit += noise_tab[r] + 2 * `RX_PSS_LEN + pay_tab[r] + GAP + 4;
        end
        sample_i  = '0;
        cfo_inc_i = '0;
        reset_ni  = 1'b0;
        row_end   = 1'b0;
        exp_nid2  = 2'd3;
        done      = 1'b0;
        repeat (5) @(posedge clk_i);
        reset_ni <= 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        repeat (GAP) @(posedge clk_i);
        done <= 1'b1;
        @(posedge clk_i);
        done <= 1'b0;
        @(posedge clk_i);
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* hw/cic_decimator.sv */
`include "rx_config.svh"

module cic_decimator import rx_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_ni,
    input  iq_stream_t in_i,
    output iq_stream_t out_o
);

    localparam int DW = `RX_SAMPLE_DW;
    localparam int CW = DW + 2;         // gain is 4 for N=2, R=2

    logic signed [CW-1:0] x       [2];
    logic signed [CW-1:0] int1    [2];
    logic signed [CW-1:0] int2    [2];
    logic signed [CW-1:0] int1_n  [2];
    logic signed [CW-1:0] int2_n  [2];
    logic signed [CW-1:0] int2_d  [2]; // int2 at the previous output
    logic signed [CW-1:0] comb1   [2];
    logic signed [CW-1:0] comb1_d [2];
    logic signed [CW-1:0] comb2   [2];
    logic                 odd;          // next sample completes a pair

    assign x[0] = in_i.data.re;
    assign x[1] = in_i.data.im;

    // index 0 is I, 1 is Q
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            int1_n[c] = int1[c] + x[c];
            int2_n[c] = int2[c] + int1_n[c];
            comb1[c]  = int2_n[c] - int2_d[c];
            comb2[c]  = comb1[c] - comb1_d[c];
        end
    end

    always_ff @(posedge clk_i) begin
        out_o.data.re <= comb2[0][CW-1:2];
        out_o.data.im <= comb2[1][CW-1:2];
        if (!reset_ni) begin
            odd         <= 1'b0;
            out_o.valid <= 1'b0;
            for (int c = 0; c < 2; c++) begin
                int1[c]    <= '0;
                int2[c]    <= '0;
                int2_d[c]  <= '0;
                comb1_d[c] <= '0;
            end
        end else begin
            out_o.valid <= in_i.valid && odd;
            if (in_i.valid) begin
                odd <= !odd;
                for (int c = 0; c < 2; c++) begin
                    int1[c] <= int1_n[c];
                    int2[c] <= int2_n[c];
                    if (odd) begin
                        int2_d[c]  <= int2_n[c];  // combs run at half rate
                        comb1_d[c] <= comb1[c];
                    end
                end
            end
        end
    end

    a_half_rate: assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_o.valid |=> !out_o.valid);

endmodule

/* hw/frame_sync.sv */
`include "rx_config.svh"

module frame_sync import rx_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_ni,
    input  iq_stream_t  in_i,
    input  pss_report_t report_i,
    output logic        search_en_o,
    output sym_out_t    sym_o
);

    localparam int CNT_W = $clog2(`RX_SYM_OFFSET + `RX_SYM_LEN + 1);

    typedef enum logic [1:0] {
        SEARCH,
        WAIT_OFFSET,
        GATE
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;           // decimated samples seen in this state
    logic [1:0]       nid2;

    always_ff @(posedge clk_i) begin
        if (state == SEARCH && report_i.valid) begin
            nid2 <= report_i.nid2;
        end
        sym_o.nid2      <= nid2;
        sym_o.sym_start <= (cnt == '0);
        sym_o.hard_bit  <= ~in_i.data.re[`RX_SAMPLE_DW-1]; // BPSK from sign of re
        if (!reset_ni) begin
            state       <= SEARCH;
            cnt         <= '0;
            search_en_o <= 1'b1;
            sym_o.valid <= 1'b0;
        end else begin
            sym_o.valid <= 1'b0;
            case (state)
                SEARCH: begin
                    if (report_i.valid) begin
                        search_en_o <= 1'b0;
                        cnt         <= '0;
                        state       <= WAIT_OFFSET;
                    end else begin
                        search_en_o <= 1'b1; // rises once the last symbol sample is out
                    end
                end
                WAIT_OFFSET: if (in_i.valid) begin
                    if (cnt == CNT_W'(`RX_SYM_OFFSET - 1)) begin
                        cnt   <= '0;
                        state <= GATE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                GATE: if (in_i.valid) begin
                    sym_o.valid <= 1'b1;
                    if (cnt == CNT_W'(`RX_SYM_LEN - 1)) begin
                        cnt   <= '0;
                        state <= SEARCH;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= SEARCH;
            endcase
        end
    end

    a_gate_no_search: assert property (@(posedge clk_i) disable iff (!reset_ni)
        sym_o.valid |-> !search_en_o);

endmodule

/* hw/nco_mixer.sv */
`include "rx_config.svh"

module nco_mixer import rx_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_ni,
    input  iq_stream_t  in_i,
    input  logic [15:0] cfo_inc_i,
    output iq_stream_t  out_o
);

    localparam int DW = `RX_SAMPLE_DW;
    localparam int PW = DW + 9;         // sample times table entry

    logic [15:0]          phase;
    logic signed [8:0]    cos_w;
    logic signed [8:0]    sin_w;
    logic                 s1_valid;
    logic signed [PW-1:0] p_re_cos;
    logic signed [PW-1:0] p_im_sin;
    logic signed [PW-1:0] p_im_cos;
    logic signed [PW-1:0] p_re_sin;
    logic signed [PW:0]   sum_re;
    logic signed [PW:0]   sum_im;

    assign cos_w = nco_cos(phase[15:13]);
    assign sin_w = nco_sin(phase[15:13]);

    // phase advances once per accepted sample
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            phase    <= '0;
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_i.valid;
            if (in_i.valid) begin
                phase <= phase + cfo_inc_i;
            end
        end
    end

    // stage 1: the four products
    always_ff @(posedge clk_i) begin
        p_re_cos <= in_i.data.re * cos_w;
        p_im_sin <= in_i.data.im * sin_w;
        p_im_cos <= in_i.data.im * cos_w;
        p_re_sin <= in_i.data.re * sin_w;
    end

    // x * conj(cos + j sin)
    assign sum_re = p_re_cos + p_im_sin;
    assign sum_im = p_im_cos - p_re_sin;

    // stage 2: drop 7 bits of table scale
    always_ff @(posedge clk_i) begin
        out_o.data.re <= sum_re[DW+6:7];
        out_o.data.im <= sum_im[DW+6:7];
        if (!reset_ni) begin
            out_o.valid <= 1'b0;
        end else begin
            out_o.valid <= s1_valid;
        end
    end

    // an output needs an input taken two cycles back, out of reset
    a_no_early_out: assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_o.valid |-> $past(in_i.valid, 2) && $past(reset_ni, 2));

endmodule

/* hw/pss_correlator.sv */
`include "rx_config.svh"

module pss_correlator import rx_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_ni,
    input  iq_stream_t  in_i,
    input  logic        search_en_i,
    output pss_report_t report_o
);

    localparam int DW = `RX_SAMPLE_DW;
    localparam int N  = `RX_PSS_LEN;
    localparam int SW = DW + $clog2(N);
    localparam int MW = SW + 1;

    iq_t                  win    [N];  // win[0] holds the oldest sample
    iq_t                  cand   [N];  // window with the incoming sample
    logic signed [SW-1:0] acc_re [3];
    logic signed [SW-1:0] acc_im [3];
    logic signed [SW-1:0] sum_re [3];
    logic signed [SW-1:0] sum_im [3];
    logic                 sum_valid;
    logic [MW-1:0]        metric [3];
    logic [MW-1:0]        best_metric;
    logic [1:0]           best;

    function automatic logic [MW-1:0] mag(input logic signed [SW-1:0] v);
        logic signed [MW-1:0] w;
        w = v;
        return w[MW-1] ? -w : w;
    endfunction

    always_comb begin
        for (int i = 0; i < N - 1; i++) begin
            cand[i] = win[i+1];
        end
        cand[N-1] = in_i.data;
    end

    // sign-only taps, so each sum is adds and subtracts
    always_comb begin
        for (int k = 0; k < 3; k++) begin
            acc_re[k] = '0;
            acc_im[k] = '0;
            for (int i = 0; i < N; i++) begin
                if (pss_tap(k, i)) begin
                    acc_re[k] = acc_re[k] - cand[i].re;
                    acc_im[k] = acc_im[k] - cand[i].im;
                end else begin
                    acc_re[k] = acc_re[k] + cand[i].re;
                    acc_im[k] = acc_im[k] + cand[i].im;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        sum_re <= acc_re;
        sum_im <= acc_im;
        if (!reset_ni) begin
            sum_valid <= 1'b0;
            for (int i = 0; i < N; i++) begin
                win[i] <= '0;
            end
        end else begin
            sum_valid <= in_i.valid;
            if (in_i.valid) begin
                win <= cand;
            end
        end
    end

    // arg-max, ties keep the lower index
    always_comb begin
        for (int k = 0; k < 3; k++) begin
            metric[k] = mag(sum_re[k]) + mag(sum_im[k]);
        end
        best        = 2'd0;
        best_metric = metric[0];
        for (int k = 1; k < 3; k++) begin
            if (metric[k] > best_metric) begin
                best        = 2'(k);
                best_metric = metric[k];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        report_o.nid2   <= best;
        report_o.metric <= best_metric;
        if (!reset_ni) begin
            report_o.valid <= 1'b0;
        end else begin
            report_o.valid <= sum_valid && search_en_i && (best_metric > MW'(`RX_PSS_THRESH));
        end
    end

    // a report always follows a decimated input by two cycles
    a_report_latency: assert property (@(posedge clk_i) disable iff (!reset_ni)
        report_o.valid |-> $past(in_i.valid, 2));

endmodule

/* hw/rx_pkg.sv */
`include "rx_config.svh"

package rx_pkg;

    typedef struct packed {
        logic signed [`RX_SAMPLE_DW-1:0] re;
        logic signed [`RX_SAMPLE_DW-1:0] im;
    } iq_t;

    typedef struct packed {
        logic valid;
        iq_t  data;
    } iq_stream_t;

    typedef struct packed {
        logic                     valid;
        logic [1:0]               nid2;
        logic [`RX_SAMPLE_DW+4:0] metric;
    } pss_report_t;

    typedef struct packed {
        logic       valid;
        logic       sym_start;
        logic [1:0] nid2;
        logic       hard_bit;
    } sym_out_t;

    // cosine scaled by 128, eight steps per turn
    function automatic logic signed [8:0] nco_cos(input logic [2:0] idx);
        case (idx)
            3'd0: return 9'sd128;
            3'd1: return 9'sd91;
            3'd2: return 9'sd0;
            3'd3: return -9'sd91;
            3'd4: return -9'sd128;
            3'd5: return -9'sd91;
            3'd6: return 9'sd0;
            default: return 9'sd91;
        endcase
    endfunction

    function automatic logic signed [8:0] nco_sin(input logic [2:0] idx);
        return nco_cos(idx - 3'd2); // sin lags cos by a quarter turn
    endfunction

    // 1 means the tap is -1
    function automatic logic pss_tap(input int seq, input int pos);
        logic [`RX_PSS_LEN-1:0] chip;
        int                     idx;
        chip    = '0;
        chip[3] = 1'b1;
        for (int i = 0; i < `RX_PSS_LEN - 4; i++) begin
            chip[i+4] = chip[i+1] ^ chip[i]; // x^4 + x + 1
        end
        idx = (pos + 5 * seq) % `RX_PSS_LEN;
        return chip[idx];
    endfunction

endpackage

/* hw/ssb_receiver.sv */
module ssb_receiver import rx_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_ni,
    input  iq_stream_t  sample_i,
    input  logic [15:0] cfo_inc_i,
    output iq_stream_t  decim_o,
    output pss_report_t report_o,
    output sym_out_t    sym_o
);

    iq_stream_t mixed;
    logic       search_en;

    nco_mixer nco_mixer_i (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .in_i      (sample_i),
        .cfo_inc_i (cfo_inc_i),
        .out_o     (mixed)
    );

    cic_decimator cic_decimator_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .in_i     (mixed),
        .out_o    (decim_o)
    );

    // correlator and frame sync both see the decimated stream
    pss_correlator pss_correlator_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_i        (decim_o),
        .search_en_i (search_en),
        .report_o    (report_o)
    );

    frame_sync frame_sync_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .in_i        (decim_o),
        .report_i    (report_o),
        .search_en_o (search_en),
        .sym_o       (sym_o)
    );

endmodule

/* include/rx_config.svh */
`ifndef RX_CONFIG_SVH
`define RX_CONFIG_SVH

// width of one I or Q component
`define RX_SAMPLE_DW 12

// taps per PSS sequence
`define RX_PSS_LEN 15

// detection level on |re| + |im| of the correlation sum
`define RX_PSS_THRESH 4000

// decimated samples skipped after the peak report
`define RX_SYM_OFFSET 4

// gated samples per symbol
`define RX_SYM_LEN 15

`endif

/* vlog.f */
+incdir+include
hw/rx_pkg.sv
hw/nco_mixer.sv
hw/cic_decimator.sv
hw/pss_correlator.sv
hw/frame_sync.sv
hw/ssb_receiver.sv
bench/rx_checker.sv
bench/tb_receiver.sv
